/* list.f */
+incdir+verif
logic/usb_rx_pkg.sv
logic/usb_line_decoder.sv
logic/usb_packet_assembler.sv
logic/usb_rx_fifo.sv
logic/usb_receiver.sv
verif/tb_usb_receiver.sv

/* logic/usb_line_decoder.sv */
// turns the D+/D- pair into a stream of data bit strobes
// NRZI decode, bit unstuffing, EOP and line fault detection

`timescale 1ns/100ps

module usb_line_decoder #(
	parameter int CLKS_PER_BIT = 8
) (
	input  logic tb_clk,
	input  logic rst_n,
	input  logic d_plus,
	input  logic d_minus,
	output logic bit_valid,
	output logic bit_value,
	output logic eop,
	output logic line_error
);

	localparam int CNT_W = $clog2(CLKS_PER_BIT);
	localparam logic [CNT_W-1:0] SAMPLE_AT = CNT_W'(CLKS_PER_BIT / 2 - 1);
	localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(CLKS_PER_BIT - 1);

	localparam int ONES_W = $clog2(usb_rx_pkg::STUFF_LIMIT + 1);
	localparam logic [ONES_W-1:0] ONES_MAX = ONES_W'(usb_rx_pkg::STUFF_LIMIT);

	// idle waits for a K, active decodes, halt waits out a broken packet
	localparam logic [1:0] ST_IDLE   = 2'd0;
	localparam logic [1:0] ST_ACTIVE = 2'd1;
	localparam logic [1:0] ST_HALT   = 2'd2;

	logic dp_s1, dp_s2;
	logic dm_s1, dm_s2;
	logic [CNT_W-1:0] bit_cnt;
	logic [1:0] state;
	logic last_level;
	logic [ONES_W-1:0] ones_cnt;
	logic [1:0] se0_cnt;

	logic line_edge;
	logic sample;
	logic is_se0;
	logic is_se1;
	logic is_j;
	logic nrzi_bit;

	// a change about to enter the second flop restarts the bit timer
	assign line_edge = (dp_s1 != dp_s2) || (dm_s1 != dm_s2);
	assign sample = (bit_cnt == SAMPLE_AT);

	assign is_se0 = !dp_s2 && !dm_s2;
	assign is_se1 = dp_s2 && dm_s2;
	assign is_j = dp_s2 && !dm_s2;

	// no transition means a one
	assign nrzi_bit = (dp_s2 == last_level);

	always_ff @(posedge tb_clk or negedge rst_n) begin
		if (!rst_n) begin
			dp_s1 <= 1'b1;
			dp_s2 <= 1'b1;
			dm_s1 <= 1'b0;
			dm_s2 <= 1'b0;
			bit_cnt <= '0;
			state <= ST_IDLE;
			last_level <= 1'b1;
			ones_cnt <= '0;
			se0_cnt <= 2'd0;
			bit_valid <= 1'b0;
			bit_value <= 1'b0;
			eop <= 1'b0;
			line_error <= 1'b0;
		end else begin
			dp_s1 <= d_plus;
			dp_s2 <= dp_s1;
			dm_s1 <= d_minus;
			dm_s2 <= dm_s1;

			bit_valid <= 1'b0;
			eop <= 1'b0;
			line_error <= 1'b0;

			if (line_edge || bit_cnt == LAST_CNT) begin
				bit_cnt <= '0;
			end else begin
				bit_cnt <= bit_cnt + 1'b1;
			end

			if (sample) begin
				case (state)
					ST_IDLE: begin
						se0_cnt <= 2'd0;
						// K out of idle is the first sync bit, a zero
						if (!is_se0 && !is_se1 && !dp_s2) begin
							state <= ST_ACTIVE;
							bit_valid <= 1'b1;
							bit_value <= 1'b0;
							last_level <= 1'b0;
							ones_cnt <= '0;
						end
					end
					ST_ACTIVE: begin
						if (is_se1) begin
							line_error <= 1'b1;
							se0_cnt <= 2'd0;
							state <= ST_HALT;
						end else if (is_se0) begin
							if (se0_cnt != 2'd3) begin
								se0_cnt <= se0_cnt + 2'd1;
							end
						end else if (se0_cnt != 2'd0) begin
							// end of an SE0 run
							se0_cnt <= 2'd0;
							if (se0_cnt >= 2'd2 && is_j) begin
								eop <= 1'b1;
								state <= ST_IDLE;
							end else begin
								line_error <= 1'b1;
								state <= ST_HALT;
							end
						end else begin
							last_level <= dp_s2;
							if (nrzi_bit) begin
								if (ones_cnt == ONES_MAX) begin
									// seventh one in a row
									line_error <= 1'b1;
									state <= ST_HALT;
								end else begin
									ones_cnt <= ones_cnt + 1'b1;
									bit_valid <= 1'b1;
									bit_value <= 1'b1;
								end
							end else begin
								ones_cnt <= '0;
								// a zero after a full run of ones is stuffing
								if (ones_cnt != ONES_MAX) begin
									bit_valid <= 1'b1;
									bit_value <= 1'b0;
								end
							end
						end
					end
					ST_HALT: begin
						if (is_se0) begin
							se0_cnt <= 2'd1;
						end else if (is_j && se0_cnt != 2'd0) begin
							se0_cnt <= 2'd0;
							state <= ST_IDLE;
						end
					end
					default: begin
						state <= ST_IDLE;
					end
				endcase
			end
		end
	end

	// the assembler treats these as exclusive events
	a_bit_not_eop: assert property (@(posedge tb_clk) disable iff (!rst_n)
		!(bit_valid && eop))
		else $error("bit strobe and EOP in the same cycle");

endmodule

/* logic/usb_packet_assembler.sv */
// collects decoded bits into bytes, checks sync and PID
// and pushes the PID and payload bytes into the receive FIFO

`timescale 1ns/100ps

module usb_packet_assembler (
	input  logic              tb_clk,
	input  logic              rst_n,
	input  logic              bit_valid,
	input  logic              bit_value,
	input  logic              eop,
	input  logic              line_error,
	input  logic              full,
	output logic              w_enable,
	output usb_rx_pkg::byte_t w_data,
	output logic              rcving,
	output logic              r_error
);

	localparam logic [2:0] A_IDLE = 3'd0;
	localparam logic [2:0] A_SYNC = 3'd1;
	localparam logic [2:0] A_PID  = 3'd2;
	localparam logic [2:0] A_DATA = 3'd3;
	localparam logic [2:0] A_WAIT = 3'd4;

	logic [2:0] state;
	logic [2:0] bit_cnt;
	usb_rx_pkg::byte_t shift_q;
	usb_rx_pkg::byte_t next_byte;
	usb_rx_pkg::pid_u pid_view;
	logic byte_done;
	logic pid_ok;

	// LSB first, so each new bit enters at the top
	assign next_byte = {bit_value, shift_q[7:1]};
	assign byte_done = (bit_cnt == 3'd7);

	always_comb begin
		pid_view.raw = next_byte;
		pid_ok = (pid_view.fields.check == ~4'(pid_view.fields.code));
	end

	always_ff @(posedge tb_clk) begin
		if (bit_valid) begin
			shift_q <= next_byte;
		end
		if (bit_valid && byte_done) begin
			w_data <= next_byte;
		end
	end

	always_ff @(posedge tb_clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= A_IDLE;
			bit_cnt <= 3'd0;
			w_enable <= 1'b0;
			rcving <= 1'b0;
			r_error <= 1'b0;
		end else begin
			w_enable <= 1'b0;

			if (line_error) begin
				r_error <= 1'b1;
				rcving <= 1'b0;
				state <= A_IDLE;
			end else if (eop) begin
				// packet must end on a byte boundary after at least a PID
				if (state == A_SYNC || state == A_PID ||
					(state == A_DATA && bit_cnt != 3'd0)) begin
					r_error <= 1'b1;
				end
				rcving <= 1'b0;
				state <= A_IDLE;
			end else if (bit_valid) begin
				bit_cnt <= bit_cnt + 3'd1;
				case (state)
					A_IDLE: begin
						// first bit of a new packet
						rcving <= 1'b1;
						r_error <= 1'b0;
						bit_cnt <= 3'd1;
						state <= A_SYNC;
					end
					A_SYNC: begin
						if (byte_done) begin
							if (next_byte == usb_rx_pkg::SYNC_BYTE) begin
								state <= A_PID;
							end else begin
								r_error <= 1'b1;
								state <= A_WAIT;
							end
						end
					end
					A_PID: begin
						if (byte_done) begin
							if (!pid_ok || full) begin
								r_error <= 1'b1;
								state <= A_WAIT;
							end else begin
								w_enable <= 1'b1;
								state <= A_DATA;
							end
						end
					end
					A_DATA: begin
						if (byte_done) begin
							if (full) begin
								// no room, byte is lost
								r_error <= 1'b1;
								state <= A_WAIT;
							end else begin
								w_enable <= 1'b1;
							end
						end
					end
					default: begin
						// wait for EOP, bits are thrown away
					end
				endcase
			end
		end
	end

	// full is sampled one cycle before the write lands
	a_no_write_full: assert property (@(posedge tb_clk) disable iff (!rst_n)
		w_enable |-> !full)
		else $error("write issued into a full FIFO");

endmodule

/* logic/usb_receiver.sv */
// top of the USB full-speed receive path
// line decoder feeds the packet assembler, which fills the read FIFO

`timescale 1ns/100ps

module usb_receiver #(
	parameter int CLKS_PER_BIT = 8,
	parameter int FIFO_DEPTH = 16
) (
	input  logic              tb_clk,
	input  logic              rst_n,
	input  logic              d_plus,
	input  logic              d_minus,
	input  logic              r_enable,
	output usb_rx_pkg::byte_t r_data,
	output logic              empty,
	output logic              full,
	output logic              rcving,
	output logic              r_error
);

	logic bit_valid;
	logic bit_value;
	logic eop;
	logic line_error;
	logic w_enable;
	usb_rx_pkg::byte_t w_data;

	usb_line_decoder #(
		.CLKS_PER_BIT(CLKS_PER_BIT)
	) u_usb_line_decoder (
		.tb_clk(tb_clk),
		.rst_n(rst_n),
		.d_plus(d_plus),
		.d_minus(d_minus),
		.bit_valid(bit_valid),
		.bit_value(bit_value),
		.eop(eop),
		.line_error(line_error)
	);

	usb_packet_assembler u_usb_packet_assembler (
		.tb_clk(tb_clk),
		.rst_n(rst_n),
		.bit_valid(bit_valid),
		.bit_value(bit_value),
		.eop(eop),
		.line_error(line_error),
		.full(full),
		.w_enable(w_enable),
		.w_data(w_data),
		.rcving(rcving),
		.r_error(r_error)
	);

	usb_rx_fifo #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) u_usb_rx_fifo (
		.tb_clk(tb_clk),
		.rst_n(rst_n),
		.w_enable(w_enable),
		.w_data(w_data),
		.r_enable(r_enable),
		.r_data(r_data),
		.empty(empty),
		.full(full)
	);

endmodule

/* logic/usb_rx_fifo.sv */
// first-word-fall-through byte FIFO between the assembler and the reader
// r_data shows the oldest byte whenever empty is low

`timescale 1ns/100ps

module usb_rx_fifo #(
	parameter int FIFO_DEPTH = 16
) (
	input  logic              tb_clk,
	input  logic              rst_n,
	input  logic              w_enable,
	input  usb_rx_pkg::byte_t w_data,
	input  logic              r_enable,
	output usb_rx_pkg::byte_t r_data,
	output logic              empty,
	output logic              full
);

	localparam int PTR_W = $clog2(FIFO_DEPTH);
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
	localparam logic [PTR_W-1:0] LAST_SLOT = PTR_W'(FIFO_DEPTH - 1);

	usb_rx_pkg::byte_t mem [FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic do_write;
	logic do_read;

	assign empty = (count == '0);
	assign full = (count == CNT_W'(FIFO_DEPTH));
	assign do_write = w_enable && !full;
	assign do_read = r_enable && !empty;
	assign r_data = mem[rd_ptr];

	always_ff @(posedge tb_clk) begin
		if (do_write) begin
			mem[wr_ptr] <= w_data;
		end
	end

	always_ff @(posedge tb_clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_write) begin
				wr_ptr <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + 1'b1;
			end
			if (do_read) begin
				rd_ptr <= (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + 1'b1;
			end
			case ({do_write, do_read})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	a_count_bound: assert property (@(posedge tb_clk) disable iff (!rst_n)
		count <= CNT_W'(FIFO_DEPTH))
		else $error("FIFO occupancy above depth");

	// the reader is expected to watch empty
	a_no_pop_empty: assert property (@(posedge tb_clk) disable iff (!rst_n)
		r_enable |-> !empty)
		else $error("read requested while FIFO empty");

endmodule

/* logic/usb_rx_pkg.sv */
// shared types and constants for the USB full-speed receive path
// referenced by scoped name from the RTL and the testbench

package usb_rx_pkg;

	// one received byte, as stored in the FIFO
	typedef logic [7:0] byte_t;

	// 4-bit PID codes, sent LSB first on the wire
	typedef enum logic [3:0] {
		PID_OUT   = 4'b0001,
		PID_IN    = 4'b1001,
		PID_SOF   = 4'b0101,
		PID_SETUP = 4'b1101,
		PID_DATA0 = 4'b0011,
		PID_DATA1 = 4'b1011,
		PID_ACK   = 4'b0010,
		PID_NAK   = 4'b1010,
		PID_STALL = 4'b1110
	} pid_code_e;

	// a PID byte seen either as the raw FIFO byte
	// or as check nibble over code nibble
	typedef union packed {
		byte_t raw;
		struct packed {
			logic [3:0] check;
			pid_code_e  code;
		} fields;
	} pid_u;

	// KJKJKJKK decodes to seven zeros and a one
	// shifted in LSB first this lands as 8'h80
	localparam byte_t SYNC_BYTE = 8'h80;

	// after this many ones in a row the sender inserts a zero
	localparam int STUFF_LIMIT = 6;

endpackage

/* run_sim.sh */
#!/bin/sh
# build the USB receiver testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
	--top-module tb_usb_receiver -Mdir obj_dir -f list.f
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

out=$(./obj_dir/Vtb_usb_receiver 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "PASS: all tests"; then
	exit 0
fi
echo "pass message not found in simulation output"
exit 1

/* verif/usb_line_tasks.svh */
// line-side helpers for the USB receiver testbench, included inside the tb module
// NRZI encoding with bit stuffing, EOP and idle on d_plus/d_minus

`ifndef USB_LINE_TASKS_SVH
`define USB_LINE_TASKS_SVH

// line level of the last bit sent, 1 for J
logic tx_level = 1'b1;
int ones_run = 0;

// one 32-bit xorshift step
function automatic logic [31:0] xorshift(input logic [31:0] s);
	logic [31:0] x;
	x = s;
	x = x ^ (x << 13);
	x = x ^ (x >> 17);
	x = x ^ (x << 5);
	return x;
endfunction

// hold one line state for a bit time, entered on a rising edge
task automatic drive_level(input logic dp, input logic dm);
	d_plus <= dp;
	d_minus <= dm;
	repeat (CLKS_PER_BIT) @(posedge tb_clk);
endtask

// a zero toggles the line, a one holds it
task automatic send_bit(input logic b);
	if (!b) begin
		tx_level = ~tx_level;
	end
	drive_level(tx_level, ~tx_level);
	ones_run = b ? ones_run + 1 : 0;
	// stuffed zero right after the run of ones
	if (ones_run == usb_rx_pkg::STUFF_LIMIT) begin
		tx_level = ~tx_level;
		drive_level(tx_level, ~tx_level);
		ones_run = 0;
	end
endtask

// LSB first
task automatic send_bits(input usb_rx_pkg::byte_t value, input int nbits);
	int i;
	for (i = 0; i < nbits; i++) begin
		send_bit(value[i]);
	end
endtask

// SE0 for two bit times, then J
task automatic send_eop();
	drive_level(1'b0, 1'b0);
	drive_level(1'b0, 1'b0);
	drive_level(1'b1, 1'b0);
endtask

task automatic send_idle(input int nbits);
	repeat (nbits) drive_level(1'b1, 1'b0);
	tx_level = 1'b1;
	ones_run = 0;
endtask

`endif

/* verif/tb_usb_receiver.sv */
// testbench for usb_receiver, drives table packets onto D+/D-
// and reads the FIFO back against a byte model

`timescale 1ns/100ps

module tb_usb_receiver;

	localparam int CLKS_PER_BIT = 8;
	localparam int FIFO_DEPTH = 16;
	localparam int NUM_ROWS = 7;

	typedef enum logic [1:0] {
		KIND_NONE,
		KIND_EOP_MID,
		KIND_NO_READ
	} err_kind_e;

	typedef struct packed {
		usb_rx_pkg::pid_code_e code;
		logic corrupt;
		int len;
		int ff_run;
		err_kind_e kind;
	} row_t;

	logic tb_clk;
	logic rst_n;
	logic d_plus;
	logic d_minus;
	logic r_enable;
	usb_rx_pkg::byte_t r_data;
	logic empty;
	logic full;
	logic rcving;
	logic r_error;

	usb_rx_pkg::byte_t exp_q [$];
	logic [31:0] rng_state = 32'h9194_ae92;
	int cycle_cnt = 0;
	int cycle_limit = 0;

	// PID code, corrupt check nibble, payload bytes, leading 0xFF bytes, error kind
	row_t rows [NUM_ROWS] = '{
		'{usb_rx_pkg::PID_IN,    1'b0, 0,  0, KIND_NONE},
		'{usb_rx_pkg::PID_ACK,   1'b0, 0,  0, KIND_NONE},
		'{usb_rx_pkg::PID_DATA0, 1'b0, 8,  3, KIND_NONE},
		'{usb_rx_pkg::PID_SETUP, 1'b1, 3,  0, KIND_NONE},
		'{usb_rx_pkg::PID_DATA0, 1'b0, 6,  0, KIND_EOP_MID},
		'{usb_rx_pkg::PID_DATA1, 1'b0, 12, 0, KIND_NO_READ},
		'{usb_rx_pkg::PID_DATA1, 1'b0, 12, 0, KIND_NONE}
	};

	`include "usb_line_tasks.svh"

	usb_receiver #(
		.CLKS_PER_BIT(CLKS_PER_BIT),
		.FIFO_DEPTH(FIFO_DEPTH)
	) u_usb_receiver (
		.tb_clk(tb_clk),
		.rst_n(rst_n),
		.d_plus(d_plus),
		.d_minus(d_minus),
		.r_enable(r_enable),
		.r_data(r_data),
		.empty(empty),
		.full(full),
		.rcving(rcving),
		.r_error(r_error)
	);

	initial begin
		tb_clk = 1'b0;
		forever #50 tb_clk = ~tb_clk;
	end

	always @(posedge tb_clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= cycle_limit) begin
			$display("timeout: run still busy after %0d clock cycles", cycle_cnt);
			stop_run();
		end
	end

	task automatic stop_run();
		$display("FAIL: see errors above");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_byte(input usb_rx_pkg::byte_t got, input usb_rx_pkg::byte_t exp,
		input string what);
		if (got !== exp) begin
			$display("ERR %0t: %s is %02h, expected %02h", $time, what, got, exp);
			stop_run();
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string name);
		if (got !== exp) begin
			$display("ERR %0t: %s is %b, expected %b", $time, name, got, exp);
			stop_run();
		end
	endtask

	// per row (payload + 4) bytes at 1.25 times the nominal bit time
	function automatic int run_limit();
		int total;
		int i;
		total = 200;
		for (i = 0; i < NUM_ROWS; i++) begin
			total += (rows[i].len + 4) * 8 * CLKS_PER_BIT * 5 / 4;
		end
		return total;
	endfunction

	// once a byte finds the FIFO full the rest of the packet is lost
	task automatic push_expected(input usb_rx_pkg::byte_t value, inout logic dropped);
		if (!dropped) begin
			if (exp_q.size() >= FIFO_DEPTH) begin
				dropped = 1'b1;
			end else begin
				exp_q.push_back(value);
			end
		end
	endtask

	// entered on a falling edge, pops one byte per pass
	task automatic read_fifo();
		usb_rx_pkg::byte_t exp;
		while (!empty) begin
			check_flag(exp_q.size() != 0, 1'b1, "byte expected in FIFO");
			exp = exp_q.pop_front();
			check_byte(r_data, exp, "r_data");
			@(posedge tb_clk);
			r_enable <= 1'b1;
			@(posedge tb_clk);
			r_enable <= 1'b0;
			@(negedge tb_clk);
		end
		check_flag(exp_q.size() == 0, 1'b1, "all expected bytes read");
	endtask

	task automatic apply_row(input row_t row);
		usb_rx_pkg::pid_u pid;
		usb_rx_pkg::byte_t data [$];
		logic exp_err;
		logic dropped;
		int full_bytes;
		int i;

		pid.fields.code = row.code;
		pid.fields.check = row.corrupt ? 4'(row.code) : ~4'(row.code);
		for (i = 0; i < row.len; i++) begin
			rng_state = xorshift(rng_state);
			data.push_back((i < row.ff_run) ? 8'hFF : rng_state[7:0]);
		end
		full_bytes = (row.kind == KIND_EOP_MID) ? row.len - 1 : row.len;

		// expected FIFO contents, nothing is written after a bad PID
		dropped = 1'b0;
		if (!row.corrupt) begin
			push_expected(pid.raw, dropped);
			for (i = 0; i < full_bytes; i++) begin
				push_expected(data[i], dropped);
			end
		end
		exp_err = row.corrupt || (row.kind == KIND_EOP_MID) || dropped;

		@(posedge tb_clk);
		send_idle(2);
		send_bits(usb_rx_pkg::SYNC_BYTE, 8);
		send_bits(pid.raw, 8);
		// receiver busy since the first sync bit
		check_flag(rcving, 1'b1, "rcving during packet");
		for (i = 0; i < full_bytes; i++) begin
			send_bits(data[i], 8);
		end
		// cut three bits into the last byte
		if (row.kind == KIND_EOP_MID) begin
			send_bits(data[row.len - 1], 3);
		end
		send_eop();
		send_idle(2);

		@(negedge tb_clk);
		while (rcving) @(negedge tb_clk);
		check_flag(r_error, exp_err, "r_error");
		check_flag(empty, exp_q.size() == 0, "empty");
		check_flag(full, exp_q.size() == FIFO_DEPTH, "full");
		if (row.kind != KIND_NO_READ) begin
			read_fifo();
		end
	endtask

	initial begin
		int r;
		rst_n = 1'b0;
		d_plus = 1'b1;
		d_minus = 1'b0;
		r_enable = 1'b0;
		cycle_limit = run_limit();
		repeat (16) @(posedge tb_clk);
		rst_n <= 1'b1;

		@(negedge tb_clk);
		check_flag(empty, 1'b1, "empty after reset");
		check_flag(full, 1'b0, "full after reset");
		check_flag(rcving, 1'b0, "rcving after reset");
		check_flag(r_error, 1'b0, "r_error after reset");

		for (r = 0; r < NUM_ROWS; r++) begin
			apply_row(rows[r]);
		end

		$display("PASS: all tests");
		$finish;
	end

endmodule
